// ==== verilog/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

////////////////////
// Storage geometry
////////////////////

// Byte address width of the data RAM
`define MEM_ADDR_BITS 12

// Word count follows from the byte address width
`define MEM_WORDS (1 << (`MEM_ADDR_BITS - 2))

////////////////////
// Display window
////////////////////

// Words shown per sweep of the monitor
`define DISP_WORDS 8

// Index width to count through the window
`define DISP_IDX_BITS 3

// Value every RAM word takes in the reset sweep
`define MEM_CLEAR_WORD 32'h0000_0000

`endif

// ==== verilog/mem_types_pkg.sv ====
`include "mem_defines.svh"

package mem_types_pkg;

    ////////////////////
    // Storage-side vector types
    ////////////////////

    // Full data word as held in the RAM
    typedef logic [31:0] word_t;

    // One enable per byte lane, bit 0 is the low byte
    typedef logic [3:0] byte_en_t;

    // Byte address as seen by the CPU
    typedef logic [`MEM_ADDR_BITS-1:0] byte_addr_t;

    // Word address into the RAM array
    // Drops the two byte-offset bits
    typedef logic [`MEM_ADDR_BITS-3:0] word_addr_t;

endpackage

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    ////////////////////
    // Memory operation codes
    ////////////////////

    // Loads first, stores last
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    ////////////////////
    // Stage payloads
    ////////////////////

    // Request from the CPU, 47 bits
    typedef struct packed {
        mem_op_e                  op;
        mem_types_pkg::byte_addr_t addr;
        mem_types_pkg::word_t     wdata;
    } mem_req_t;

    // Access presented to the RAM port
    typedef struct packed {
        logic                      we;
        mem_types_pkg::byte_en_t   be;
        mem_types_pkg::word_addr_t addr;
        mem_types_pkg::word_t      wdata;
    } ram_acc_t;

    // Result returned one cycle after the request
    typedef struct packed {
        mem_types_pkg::word_t ldata;
        logic                 misalign;
    } mem_rsp_t;

endpackage

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module data_ram (
    input  logic                      clk,
    input  logic                      rst,
    input  lsu_pkg::ram_acc_t         acc,
    output mem_types_pkg::word_t      rdata,
    input  mem_types_pkg::word_addr_t disp_addr,
    output mem_types_pkg::word_t      disp_data
);

    // Word array, one entry per word address
    mem_types_pkg::word_t mem [`MEM_WORDS];

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Sweep every word back to the clear value
            for (int i = 0; i < `MEM_WORDS; i++)
            begin
                mem[i] <= `MEM_CLEAR_WORD;
            end
        end
        else if (acc.we)
        begin
            // Only the enabled lanes change
            for (int b = 0; b < 4; b++)
            begin
                if (acc.be[b])
                begin
                    mem[acc.addr][b*8 +: 8] <= acc.wdata[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // Both ports sample the word before this edge's write lands
    always_ff @(posedge clk)
    begin
        rdata     <= mem[acc.addr];
        disp_data <= mem[disp_addr];
    end

    // Controller and aligner never issue an empty write
    a_no_empty_write : assert property (
        @(posedge clk) disable iff (rst)
        acc.we |-> (acc.be != '0)
    );

endmodule

// ==== verilog/store_align.sv ====
`timescale 1ns/1ns

module store_align (
    input  lsu_pkg::mem_op_e        op,
    input  logic [1:0]              addr_lo,
    input  mem_types_pkg::word_t    wdata,
    output mem_types_pkg::word_t    lane_data,
    output mem_types_pkg::byte_en_t byte_en
);

    ////////////////////
    // Lane placement
    ////////////////////

    // Data is replicated across lanes, the enables pick the real one
    always_comb
    begin
        lane_data = wdata;
        byte_en   = '0;
        case (op)
            lsu_pkg::OP_SB:
            begin
                // Low byte copied to all four lanes
                lane_data = {4{wdata[7:0]}};
                byte_en   = 4'b0001 << addr_lo;
            end
            lsu_pkg::OP_SH:
            begin
                // Low half copied to both halves
                lane_data = {2{wdata[15:0]}};
                // Bit 1 picks the upper or lower half
                byte_en   = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            lsu_pkg::OP_SW:
            begin
                byte_en = 4'b1111;
            end
            default:
            begin
                // Loads leave every lane disabled
                byte_en = '0;
            end
        endcase
    end

endmodule

// ==== verilog/load_extend.sv ====
`timescale 1ns/1ns

module load_extend (
    input  lsu_pkg::mem_op_e     op,
    input  logic [1:0]           addr_lo,
    input  mem_types_pkg::word_t rword,
    output mem_types_pkg::word_t ldata
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    ////////////////////
    // Lane select
    ////////////////////

    always_comb
    begin
        case (addr_lo)
            2'd0:    sel_byte = rword[7:0];
            2'd1:    sel_byte = rword[15:8];
            2'd2:    sel_byte = rword[23:16];
            default: sel_byte = rword[31:24];
        endcase
        // Halfword lane, bit 0 ignored here
        sel_half = addr_lo[1] ? rword[31:16] : rword[15:0];
    end

    ////////////////////
    // Extension
    ////////////////////

    always_comb
    begin
        case (op)
            lsu_pkg::OP_LB:  ldata = {{24{sel_byte[7]}}, sel_byte};
            lsu_pkg::OP_LBU: ldata = {24'h0, sel_byte};
            lsu_pkg::OP_LH:  ldata = {{16{sel_half[15]}}, sel_half};
            lsu_pkg::OP_LHU: ldata = {16'h0, sel_half};
            lsu_pkg::OP_LW:  ldata = rword;
            // Stores carry no load data
            default:         ldata = '0;
        endcase
    end

endmodule

// ==== verilog/lsu_ctrl.sv ====
`timescale 1ns/1ns

module lsu_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  lsu_pkg::mem_req_t       req,
    input  mem_types_pkg::word_t    lane_data,
    input  mem_types_pkg::byte_en_t byte_en,
    output lsu_pkg::ram_acc_t       acc,
    output lsu_pkg::mem_op_e        held_op,
    output logic [1:0]              held_lo,
    input  mem_types_pkg::word_t    ldata,
    output logic                    rsp_valid,
    output lsu_pkg::mem_rsp_t       rsp
);

    logic misalign;
    logic is_store;
    logic held_mis;
    logic held_store;

    ////////////////////
    // Request decode
    ////////////////////

    always_comb
    begin
        case (req.op)
            // Halfwords need an even address
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH:
                misalign = req.addr[0];
            // Words need both low bits clear
            lsu_pkg::OP_LW, lsu_pkg::OP_SW:
                misalign = |req.addr[1:0];
            default:
                misalign = 1'b0;
        endcase
        is_store = req.op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
    end

    // RAM access, write only for a valid aligned store
    always_comb
    begin
        acc.we    = req_valid && is_store && !misalign;
        acc.be    = byte_en;
        acc.addr  = mem_types_pkg::word_addr_t'(req.addr >> 2);
        acc.wdata = lane_data;
    end

    ////////////////////
    // Response timing
    ////////////////////

    // One pulse per request, a cycle later
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= req_valid;
        end
    end

    // Context lined up with the RAM read word
    always_ff @(posedge clk)
    begin
        held_op  <= req.op;
        held_lo  <= req.addr[1:0];
        held_mis <= misalign;
    end

    // Stores and misaligned accesses answer with zero data
    always_comb
    begin
        held_store   = held_op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
        rsp.ldata    = (held_store || held_mis) ? '0 : ldata;
        rsp.misalign = held_mis;
    end

    // Each request gets its pulse, and no pulse appears on its own
    a_rsp_follows_req : assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid == $past(req_valid)
    );

endmodule

// ==== verilog/display_scan.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module display_scan (
    input  logic                      clk,
    input  logic                      rst,
    input  mem_types_pkg::word_addr_t disp_base,
    output mem_types_pkg::word_addr_t disp_addr,
    input  mem_types_pkg::word_t      disp_data,
    output logic [`DISP_IDX_BITS-1:0] disp_index,
    output mem_types_pkg::word_t      disp_word
);

    // Offset being read now, and the one whose word is arriving
    logic [`DISP_IDX_BITS-1:0] offset;
    logic [`DISP_IDX_BITS-1:0] offset_q;

    ////////////////////
    // Window sweep
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            offset   <= '0;
            offset_q <= '0;
        end
        else
        begin
            // Wrap at the end of the window
            if (offset == `DISP_IDX_BITS'(`DISP_WORDS - 1))
                offset <= '0;
            else
                offset <= offset + 1'b1;
            // Match the RAM read latency
            offset_q <= offset;
        end
    end

    // Window starts at the base word
    assign disp_addr = disp_base + mem_types_pkg::word_addr_t'(offset);

    // Word and label leave together
    assign disp_index = offset_q;
    assign disp_word  = disp_data;

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  lsu_pkg::mem_req_t         req,
    output logic                      rsp_valid,
    output lsu_pkg::mem_rsp_t         rsp,
    input  mem_types_pkg::word_addr_t disp_base,
    output logic [2:0]                disp_index,
    output mem_types_pkg::word_t      disp_word
);

    ////////////////////
    // Internal nets
    ////////////////////

    mem_types_pkg::word_t      lane_data;
    mem_types_pkg::byte_en_t   byte_en;
    lsu_pkg::ram_acc_t         acc;
    lsu_pkg::mem_op_e          held_op;
    logic [1:0]                held_lo;
    mem_types_pkg::word_t      rdata;
    mem_types_pkg::word_t      ldata;
    mem_types_pkg::word_addr_t disp_addr;
    mem_types_pkg::word_t      disp_data;

    // Request side, combinational lane placement
    store_align u_store_align (
        .op        (req.op),
        .addr_lo   (req.addr[1:0]),
        .wdata     (req.wdata),
        .lane_data (lane_data),
        .byte_en   (byte_en)
    );

    lsu_ctrl u_lsu_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .lane_data (lane_data),
        .byte_en   (byte_en),
        .acc       (acc),
        .held_op   (held_op),
        .held_lo   (held_lo),
        .ldata     (ldata),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .rst       (rst),
        .acc       (acc),
        .rdata     (rdata),
        .disp_addr (disp_addr),
        .disp_data (disp_data)
    );

    // Response side, uses the held context
    load_extend u_load_extend (
        .op      (held_op),
        .addr_lo (held_lo),
        .rword   (rdata),
        .ldata   (ldata)
    );

    display_scan u_display_scan (
        .clk        (clk),
        .rst        (rst),
        .disp_base  (disp_base),
        .disp_addr  (disp_addr),
        .disp_data  (disp_data),
        .disp_index (disp_index),
        .disp_word  (disp_word)
    );

endmodule

// ==== testbench/tb_mem_stage.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module tb_mem_stage;

    ////////////////////
    // Run lengths
    ////////////////////

    localparam int N_STORE        = 200;
    localparam int N_EXT          = 24;
    localparam int N_MIS          = 100;
    localparam int N_B2B          = 600;
    localparam int N_PAIRS        = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int DISP_CYCLES    = 2 * `DISP_WORDS + 10;
    // Sweep, store rounds, extension words, misaligned pairs, random, store-load pairs
    localparam int N_REQ = `MEM_WORDS + 2 * N_STORE + 13 * N_EXT + 2 * N_MIS
                         + N_B2B + 2 * N_PAIRS;
    localparam int TIMEOUT_CYCLES = 2 * N_REQ + RESET_CYCLES + DISP_CYCLES;

    logic                      clk;
    logic                      rst;
    logic                      req_valid;
    lsu_pkg::mem_req_t         req;
    logic                      rsp_valid;
    lsu_pkg::mem_rsp_t         rsp;
    mem_types_pkg::word_addr_t disp_base;
    logic [2:0]                disp_index;
    mem_types_pkg::word_t      disp_word;

    // Reference memory with one entry per RAM word
    mem_types_pkg::word_t      model [`MEM_WORDS];
    lsu_pkg::mem_rsp_t         exp_q [$];
    lsu_pkg::mem_rsp_t         exp_now;
    logic [31:0]               lfsr;
    int                        n_checks;
    int                        n_errors;
    int                        cycle_count;
    logic                      disp_check;
    logic                      have_prev;
    logic [2:0]                prev_index;
    mem_types_pkg::word_addr_t region_base;

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .disp_base  (disp_base),
        .disp_index (disp_index),
        .disp_word  (disp_word)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb)
                lfsr = lfsr ^ 32'h8020_0003;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    // Access size in bytes
    function automatic int op_bytes(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: return 1;
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_store(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
    endfunction

    // An access must start on a multiple of its size
    function automatic logic misaligned(input lsu_pkg::mem_req_t r);
        return (int'(r.addr) % op_bytes(r.op)) != 0;
    endfunction

    function automatic mem_types_pkg::word_addr_t word_index(
        input mem_types_pkg::byte_addr_t a);
        return mem_types_pkg::word_addr_t'(a >> 2);
    endfunction

    // Expected response from the model before this request's write lands
    function automatic lsu_pkg::mem_rsp_t expect_rsp(input lsu_pkg::mem_req_t r);
        lsu_pkg::mem_rsp_t    res;
        mem_types_pkg::word_t w;
        logic [7:0]           b;
        logic [15:0]          h;
        w            = model[word_index(r.addr)];
        b            = w[8 * int'(r.addr[1:0]) +: 8];
        h            = w[16 * int'(r.addr[1]) +: 16];
        res.misalign = misaligned(r);
        res.ldata    = '0;
        if (!res.misalign)
        begin
            case (r.op)
                lsu_pkg::OP_LB:  res.ldata = 32'($signed(b));
                lsu_pkg::OP_LBU: res.ldata = 32'(b);
                lsu_pkg::OP_LH:  res.ldata = 32'($signed(h));
                lsu_pkg::OP_LHU: res.ldata = 32'(h);
                lsu_pkg::OP_LW:  res.ldata = w;
                default:         res.ldata = '0;
            endcase
        end
        return res;
    endfunction

    // Write the addressed bytes of an aligned store into the model
    task automatic apply_store(input lsu_pkg::mem_req_t r);
        mem_types_pkg::word_t w;
        int                   lo;
        if (is_store(r.op) && !misaligned(r))
        begin
            w  = model[word_index(r.addr)];
            lo = int'(r.addr[1:0]);
            for (int i = 0; i < op_bytes(r.op); i++)
                w[8 * (lo + i) +: 8] = r.wdata[8 * i +: 8];
            model[word_index(r.addr)] = w;
        end
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("error at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic issue(input lsu_pkg::mem_op_e op, input mem_types_pkg::byte_addr_t addr,
                         input mem_types_pkg::word_t data);
        lsu_pkg::mem_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = data;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    ////////////////////
    // Checker
    ////////////////////

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            // Display word against the model window
            if (disp_check)
            begin
                check_value(64'(disp_word),
                            64'(model[mem_types_pkg::word_addr_t'(disp_base + disp_index)]),
                            "display word");
                if (have_prev)
                    check_value(64'(disp_index), 64'((prev_index + 1) % `DISP_WORDS),
                                "display index step");
                have_prev  = 1'b1;
                prev_index = disp_index;
            end
            else
            begin
                have_prev = 1'b0;
            end
            // Response for last cycle's request
            if (exp_q.size() != 0)
            begin
                exp_now = exp_q.pop_front();
                check_value(64'(rsp_valid), 64'(1), "rsp_valid after request");
                if (rsp_valid)
                    check_value(64'(rsp), 64'(exp_now), "response");
            end
            else
            begin
                check_value(64'(rsp_valid), 64'(0), "rsp_valid without request");
            end
            // This cycle's request and then its write
            if (req_valid)
            begin
                exp_q.push_back(expect_rsp(req));
                apply_store(req);
            end
        end
    end

    // Cycle limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial
    begin
        logic [31:0]                data;
        logic [1:0]                 lo;
        mem_types_pkg::byte_addr_t  addr;
        lsu_pkg::mem_op_e           op;
        lsu_pkg::mem_op_e           mis_ops [5];
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        disp_base   = '0;
        lfsr        = 32'ha0ca4095;
        n_checks    = 0;
        n_errors    = 0;
        cycle_count = 0;
        disp_check  = 1'b0;
        have_prev   = 1'b0;
        prev_index  = '0;
        mis_ops     = '{lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH,
                        lsu_pkg::OP_LW, lsu_pkg::OP_SW};
        for (int i = 0; i < `MEM_WORDS; i++)
            model[i] = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(64'(disp_index), 64'(0), "display index after reset");

        // Cleared RAM read with idle gaps between groups of loads
        for (int i = 0; i < `MEM_WORDS; i++)
        begin
            issue(lsu_pkg::OP_LW, mem_types_pkg::byte_addr_t'(i << 2), '0);
            if (i % 4 == 3)
                idle_cycles(1);
        end

        // Aligned stores of every size each read back as a word
        for (int i = 0; i < N_STORE; i++)
        begin
            op   = lsu_pkg::mem_op_e'(3'd5 + 3'(take_bits(2) % 3));
            addr = mem_types_pkg::byte_addr_t'(take_bits(`MEM_ADDR_BITS));
            if (op == lsu_pkg::OP_SH)
                addr[0] = 1'b0;
            if (op == lsu_pkg::OP_SW)
                addr[1:0] = 2'b00;
            issue(op, addr, take_bits(32));
            issue(lsu_pkg::OP_LW, {addr[`MEM_ADDR_BITS-1:2], 2'b00}, '0);
        end

        // Every byte and halfword lane in both sign polarities
        for (int w = 0; w < N_EXT; w++)
        begin
            addr = {mem_types_pkg::word_addr_t'(take_bits(`MEM_ADDR_BITS - 2)), 2'b00};
            data = take_bits(32);
            data = (w % 2 == 0) ? (data | 32'h8080_8080) : (data & 32'h7f7f_7f7f);
            issue(lsu_pkg::OP_SW, addr, data);
            for (int b = 0; b < 4; b++)
            begin
                issue(lsu_pkg::OP_LB, addr | mem_types_pkg::byte_addr_t'(b), '0);
                issue(lsu_pkg::OP_LBU, addr | mem_types_pkg::byte_addr_t'(b), '0);
            end
            for (int h = 0; h < 2; h++)
            begin
                issue(lsu_pkg::OP_LH, addr | mem_types_pkg::byte_addr_t'(2 * h), '0);
                issue(lsu_pkg::OP_LHU, addr | mem_types_pkg::byte_addr_t'(2 * h), '0);
            end
        end

        // Misaligned halfword and word accesses followed by the word they touched
        for (int i = 0; i < N_MIS; i++)
        begin
            op   = mis_ops[take_bits(3) % 5];
            addr = mem_types_pkg::byte_addr_t'(take_bits(`MEM_ADDR_BITS));
            lo   = addr[1:0];
            if (op_bytes(op) == 2)
                lo[0] = 1'b1;
            else if (lo == 2'b00)
                lo = 2'b11;
            addr[1:0] = lo;
            issue(op, addr, take_bits(32));
            issue(lsu_pkg::OP_LW, {addr[`MEM_ADDR_BITS-1:2], 2'b00}, '0);
        end

        // Every cycle busy inside a 16-word region
        region_base = mem_types_pkg::word_addr_t'(take_bits(`MEM_ADDR_BITS - 2));
        for (int i = 0; i < N_B2B; i++)
        begin
            op   = lsu_pkg::mem_op_e'(take_bits(3));
            addr = {region_base + mem_types_pkg::word_addr_t'(take_bits(4)),
                    2'(take_bits(2))};
            issue(op, addr, take_bits(32));
        end
        // Store then load of the same word on the next cycle
        for (int i = 0; i < N_PAIRS; i++)
        begin
            addr = {region_base + mem_types_pkg::word_addr_t'(take_bits(4)), 2'b00};
            issue(lsu_pkg::OP_SW, addr, take_bits(32));
            issue(lsu_pkg::OP_LW, addr, '0);
        end

        // Display sweep over a quiet memory
        idle_cycles(4);
        @(posedge clk);
        disp_base <= region_base + mem_types_pkg::word_addr_t'(take_bits(3));
        idle_cycles(3);
        disp_check = 1'b1;
        repeat (2 * `DISP_WORDS + 2) @(posedge clk);
        disp_check = 1'b0;
        idle_cycles(3);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/mem_types_pkg.sv
verilog/lsu_pkg.sv
verilog/data_ram.sv
verilog/store_align.sv
verilog/load_extend.sv
verilog/lsu_ctrl.sv
verilog/display_scan.sv
verilog/mem_stage.sv
testbench/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_mem_stage \
    -f flist.f \
    --Mdir obj_dir \
    -o sim_mem_stage

./obj_dir/sim_mem_stage | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL, see sim.log"
    exit 1
fi
